// ==== files.f ====
exu_pkg.sv
exu_regfile.sv
exu_alu.sv
exu_lsu.sv
exu_ctrl.sv
exu_top.sv
tb_exu_mem.sv
tb_exu_top.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_exu_top \
		-f files.f --Mdir obj_dir -o sim
	-./obj_dir/sim > sim.log 2>&1
	@cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log || { echo "no pass line in log"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// ==== tb_exu_top.sv ====
`timescale 1ns/1ns

module tb_exu_top;
    import exu_pkg::*;

    typedef struct packed {
        exu_insn_t   insn;
        logic        wen;
        logic [63:0] value;
        logic [63:0] npc;
        logic [7:0]  strb;
    } row_t;

    logic         clk;
    logic         rst;
    exu_insn_t    insn;
    logic         insn_valid;
    logic         insn_ready;
    exu_retire_t  retire;
    logic         retire_valid;
    logic         retire_ready;
    mem_ar_t      ar;
    logic         ar_valid;
    logic         ar_ready;
    mem_r_t       r;
    logic         r_valid;
    logic         r_ready;
    mem_aw_t      aw;
    logic         aw_valid;
    logic         aw_ready;
    mem_w_t       w;
    logic         w_valid;
    logic         w_ready;
    logic [1:0]   b_resp;
    logic         b_valid;
    logic         b_ready;
    logic [7:0]   last_strb;
    row_t         rows[$];
    string        names[$];

    exu_top u_dut (.*);

    tb_exu_mem u_mem (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic check(string name, logic [63:0] exp, logic [63:0] act);
        if (exp !== act) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic timed_out(string what);
        $display("timeout while waiting for %s", what);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // pc is implied by the row position
    task automatic add_row(string name, exu_op_e op, reg_idx_t rd, reg_idx_t rs1,
                           reg_idx_t rs2, logic use_imm, logic [63:0] imm, logic wen,
                           logic [63:0] value, longint npc_off, logic [7:0] strb);
        row_t rw;
        rw.insn.op = op;
        rw.insn.rd = rd;
        rw.insn.rs1 = rs1;
        rw.insn.rs2 = rs2;
        rw.insn.use_imm = use_imm;
        rw.insn.imm = imm;
        rw.insn.pc = 64'h1000 + 64'(rows.size() * 4);
        rw.wen = wen;
        rw.value = value;
        rw.npc = rw.insn.pc + 64'(npc_off);
        rw.strb = strb;
        rows.push_back(rw);
        names.push_back(name);
    endtask

    task automatic build_table();
        // x1 = 0x40, x2 = -3
        add_row("addi_x1", op_add, 1, 0, 0, 1, 64'h40, 1, 64'h40, 4, 0);
        add_row("addi_x2", op_add, 2, 0, 0, 1, 64'hffff_ffff_ffff_fffd, 1,
                64'hffff_ffff_ffff_fffd, 4, 0);
        add_row("add", op_add, 3, 1, 2, 0, 0, 1, 64'h3d, 4, 0);
        add_row("sub", op_sub, 4, 1, 2, 0, 0, 1, 64'h43, 4, 0);
        add_row("slli", op_sll, 5, 1, 0, 1, 64'd4, 1, 64'h400, 4, 0);
        add_row("srli", op_srl, 6, 2, 0, 1, 64'd60, 1, 64'hf, 4, 0);
        add_row("srai", op_sra, 7, 2, 0, 1, 64'd1, 1, 64'hffff_ffff_ffff_fffe, 4, 0);
        add_row("and", op_and, 8, 1, 2, 0, 0, 1, 64'h40, 4, 0);
        add_row("ori", op_or, 9, 1, 0, 1, 64'h3, 1, 64'h43, 4, 0);
        add_row("xor", op_xor, 10, 2, 1, 0, 0, 1, 64'hffff_ffff_ffff_ffbd, 4, 0);
        add_row("slt", op_slt, 11, 2, 1, 0, 0, 1, 64'd1, 4, 0);
        add_row("sltu", op_sltu, 12, 2, 1, 0, 0, 1, 64'd0, 4, 0);
        add_row("lui", op_lui, 13, 0, 0, 1, 64'hffff_ffff_8765_4000, 1,
                64'hffff_ffff_8765_4000, 4, 0);
        // x0 target retires with wen but keeps zero
        add_row("x0_write", op_add, 0, 0, 0, 1, 64'h55, 1, 64'h55, 4, 0);
        add_row("x0_read", op_add, 14, 0, 0, 0, 0, 1, 64'd0, 4, 0);
        add_row("beq_t", op_beq, 0, 1, 1, 0, 64'h20, 0, 0, 64'h20, 0);
        add_row("beq_nt", op_beq, 0, 1, 2, 0, 64'h20, 0, 0, 4, 0);
        add_row("bne_t", op_bne, 0, 1, 2, 0, 64'hffff_ffff_ffff_fff8, 0, 0, -8, 0);
        add_row("bne_nt", op_bne, 0, 1, 1, 0, 64'hffff_ffff_ffff_fff8, 0, 0, 4, 0);
        add_row("blt_t", op_blt, 0, 2, 1, 0, 64'h10, 0, 0, 64'h10, 0);
        add_row("blt_nt", op_blt, 0, 1, 2, 0, 64'h10, 0, 0, 4, 0);
        add_row("bgeu_t", op_bgeu, 0, 2, 1, 0, 64'h40, 0, 0, 64'h40, 0);
        add_row("bgeu_nt", op_bgeu, 0, 1, 2, 0, 64'h40, 0, 0, 4, 0);
        // jal at 0x105c, jalr at 0x1060 jumps to (0x1060 + 0x21) & ~1
        add_row("jal", op_jal, 15, 0, 0, 1, 64'h100, 1, 64'h1060, 64'h100, 0);
        add_row("jalr", op_jalr, 16, 15, 0, 1, 64'h21, 1, 64'h1064, 64'h20, 0);
        add_row("sb_lane1", op_sb, 0, 1, 10, 1, 64'h1, 0, 0, 4, 8'h02);
        add_row("sh_lane2", op_sh, 0, 1, 13, 1, 64'ha, 0, 0, 4, 8'h0c);
        add_row("sw_lane4", op_sw, 0, 1, 13, 1, 64'h14, 0, 0, 4, 8'hf0);
        add_row("sd_lane0", op_sd, 0, 1, 10, 1, 64'h18, 0, 0, 4, 8'hff);
        add_row("lb", op_lb, 18, 1, 0, 1, 64'h1, 1, 64'hffff_ffff_ffff_ffbd, 4, 0);
        add_row("lbu", op_lbu, 19, 1, 0, 1, 64'h1, 1, 64'hbd, 4, 0);
        add_row("lh_pattern", op_lh, 20, 0, 0, 1, 64'hc6, 1, 64'hffff_ffff_ffff_9d9c, 4, 0);
        add_row("lhu_stored", op_lhu, 21, 1, 0, 1, 64'ha, 1, 64'h4000, 4, 0);
        add_row("lhu_pattern", op_lhu, 22, 0, 0, 1, 64'hc6, 1, 64'h9d9c, 4, 0);
        add_row("lw", op_lw, 23, 1, 0, 1, 64'h14, 1, 64'hffff_ffff_8765_4000, 4, 0);
        add_row("lwu", op_lwu, 24, 1, 0, 1, 64'h14, 1, 64'h8765_4000, 4, 0);
        add_row("ld_stored", op_ld, 25, 1, 0, 1, 64'h18, 1, 64'hffff_ffff_ffff_ffbd, 4, 0);
        // mixes pattern bytes and the sh bytes
        add_row("ld_mixed", op_ld, 26, 1, 0, 1, 64'h8, 1, 64'h1514_1716_4000_1312, 4, 0);
        add_row("ld_sb", op_ld, 27, 1, 0, 1, 64'h0, 1, 64'h1d1c_1f1e_1918_bd1a, 4, 0);
    endtask

    task automatic run_row(int i, bit stall);
        int   n;
        bit   seen;
        bit   done;
        bit   is_mem;
        row_t rw;
        rw = rows[i];
        seen = 0;
        done = 0;
        is_mem = rw.insn.op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld,
                                    op_sb, op_sh, op_sw, op_sd};
        @(posedge clk);
        insn <= rw.insn;
        insn_valid <= 1'b1;
        retire_ready <= stall ? 1'($urandom % 2) : 1'b1;
        n = 0;
        @(negedge clk);
        while (!insn_ready) begin
            n++;
            if (n > 50) timed_out("insn_ready");
            @(negedge clk);
        end
        // transfer edge
        @(posedge clk);
        insn_valid <= 1'b0;
        if (stall) retire_ready <= 1'($urandom % 2);
        n = 0;
        while (!done) begin
            @(negedge clk);
            n++;
            check({names[i], " insn_ready"}, 64'd0, 64'(insn_ready));
            if (retire_valid && !seen) begin
                seen = 1;
                if (!stall && !is_mem) check({names[i], " latency"}, 64'd2, 64'(n));
            end
            if (retire_valid && retire_ready) begin
                done = 1;
            end else begin
                if (n > 200) timed_out("retire_valid");
                @(posedge clk);
                if (stall) retire_ready <= 1'($urandom % 2);
            end
        end
        check({names[i], " wen"}, 64'(rw.wen), 64'(retire.wen));
        check({names[i], " next_pc"}, rw.npc, retire.next_pc);
        if (rw.wen) begin
            check({names[i], " rd"}, 64'(rw.insn.rd), 64'(retire.rd));
            check({names[i], " value"}, rw.value, retire.value);
        end
        if (rw.strb != 0) check({names[i], " strb"}, 64'(rw.strb), 64'(last_strb));
    endtask

    initial begin
        void'($urandom(32'hd055_c17e));
        rst = 1'b1;
        insn = '0;
        insn_valid = 1'b0;
        retire_ready = 1'b0;
        build_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // second pass repeats the table under retire stalls
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < rows.size(); i++) begin
                run_row(i, pass == 1);
            end
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== tb_exu_mem.sv ====
`timescale 1ns/1ns

module tb_exu_mem (
    input  logic                clk,
    input  logic                rst,
    input  exu_pkg::mem_ar_t    ar,
    input  logic                ar_valid,
    output logic                ar_ready,
    output exu_pkg::mem_r_t     r,
    output logic                r_valid,
    input  logic                r_ready,
    input  exu_pkg::mem_aw_t    aw,
    input  logic                aw_valid,
    output logic                aw_ready,
    input  exu_pkg::mem_w_t     w,
    input  logic                w_valid,
    output logic                w_ready,
    output logic [1:0]          b_resp,
    output logic                b_valid,
    input  logic                b_ready,
    output logic [7:0]          last_strb
);
    import exu_pkg::*;

    // 64 words of 8 bytes, 512 bytes in all
    logic [63:0] mem [0:63];
    logic        rd_pend;
    logic [31:0] rd_addr;
    logic        got_aw;
    logic        got_w;
    logic [31:0] waddr_q;
    mem_w_t      w_q;

    initial begin
        // byte value follows its address so loads are predictable
        for (int a = 0; a < 512; a++) begin
            mem[a / 8][(a % 8) * 8 +: 8] = 8'(a) ^ 8'h5a ^ 8'(a >> 8);
        end
        ar_ready = 1'b0;
        r = '0;
        r_valid = 1'b0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_resp = resp_okay;
        b_valid = 1'b0;
        last_strb = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            ar_ready <= 1'b0;
            r_valid <= 1'b0;
            aw_ready <= 1'b0;
            w_ready <= 1'b0;
            b_valid <= 1'b0;
            rd_pend <= 1'b0;
            got_aw <= 1'b0;
            got_w <= 1'b0;
        end else begin
            // random ready delays on the request side
            ar_ready <= 1'($urandom % 2);
            aw_ready <= 1'($urandom % 2);
            w_ready <= 1'($urandom % 2);
            if (ar_valid && ar_ready) begin
                rd_pend <= 1'b1;
                rd_addr <= ar.addr;
            end
            if (rd_pend && !r_valid && 1'($urandom % 2)) begin
                r_valid <= 1'b1;
                r <= '{data: mem[rd_addr[8:3]], resp: resp_okay};
                rd_pend <= 1'b0;
            end
            if (r_valid && r_ready) begin
                r_valid <= 1'b0;
            end
            if (aw_valid && aw_ready) begin
                got_aw <= 1'b1;
                waddr_q <= aw.addr;
            end
            if (w_valid && w_ready) begin
                got_w <= 1'b1;
                w_q <= w;
                last_strb <= w.strb;
            end
            // commit the strobed bytes once both halves arrived
            if (got_aw && got_w && !b_valid && 1'($urandom % 2)) begin
                for (int k = 0; k < 8; k++) begin
                    if (w_q.strb[k]) begin
                        mem[waddr_q[8:3]][k * 8 +: 8] <= w_q.data[k * 8 +: 8];
                    end
                end
                got_aw <= 1'b0;
                got_w <= 1'b0;
                b_valid <= 1'b1;
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== exu_top.sv ====
`timescale 1ns/1ns

module exu_top (
    input  logic                        clk,
    input  logic                        rst,
    input  exu_pkg::exu_insn_t          insn,
    input  logic                        insn_valid,
    output logic                        insn_ready,
    output exu_pkg::exu_retire_t        retire,
    output logic                        retire_valid,
    input  logic                        retire_ready,
    output exu_pkg::mem_ar_t            ar,
    output logic                        ar_valid,
    input  logic                        ar_ready,
    input  exu_pkg::mem_r_t             r,
    input  logic                        r_valid,
    output logic                        r_ready,
    output exu_pkg::mem_aw_t            aw,
    output logic                        aw_valid,
    input  logic                        aw_ready,
    output exu_pkg::mem_w_t             w,
    output logic                        w_valid,
    input  logic                        w_ready,
    input  logic [1:0]                  b_resp,
    input  logic                        b_valid,
    output logic                        b_ready
);
    import exu_pkg::*;

    exu_insn_t       cur_insn;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] next_pc;
    logic            mem_start;
    logic            mem_done;
    logic [xlen-1:0] load_value;
    logic            rf_wen;
    reg_idx_t        rf_waddr;
    logic [xlen-1:0] rf_wdata;

    // sequencing and retire
    exu_ctrl u_ctrl (.*);

    // operands come straight from the held instruction
    exu_regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (cur_insn.rs1),
        .raddr2 (cur_insn.rs2),
        .rdata1 (src1),
        .rdata2 (src2),
        .wen    (rf_wen),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    exu_alu u_alu (
        .insn    (cur_insn),
        .src1    (src1),
        .src2    (src2),
        .result  (alu_result),
        .next_pc (next_pc)
    );

    // alu sum is the effective address, rs2 the store data
    exu_lsu u_lsu (
        .*,
        .addr      (alu_result),
        .store_src (src2)
    );

endmodule

// ==== exu_ctrl.sv ====
`timescale 1ns/1ns

module exu_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  exu_pkg::exu_insn_t          insn,
    input  logic                        insn_valid,
    output logic                        insn_ready,
    output exu_pkg::exu_insn_t          cur_insn,
    input  logic [exu_pkg::xlen-1:0]    alu_result,
    input  logic [exu_pkg::xlen-1:0]    next_pc,
    output logic                        mem_start,
    input  logic                        mem_done,
    input  logic [exu_pkg::xlen-1:0]    load_value,
    output exu_pkg::exu_retire_t        retire,
    output logic                        retire_valid,
    input  logic                        retire_ready,
    output logic                        rf_wen,
    output exu_pkg::reg_idx_t           rf_waddr,
    output logic [exu_pkg::xlen-1:0]    rf_wdata
);
    import exu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_exec,
        st_mem_wait,
        st_retire
    } ctrl_state_e;

    ctrl_state_e state;
    logic        is_mem;
    logic        no_write;
    exu_retire_t rec;

    always_comb begin
        is_mem = is_load(cur_insn.op) || is_store(cur_insn.op);
        // stores and branches leave rd alone
        no_write = is_store(cur_insn.op) ||
                   (cur_insn.op inside {op_beq, op_bne, op_blt, op_bgeu});
        rec.rd = cur_insn.rd;
        rec.wen = !no_write;
        rec.next_pc = next_pc;
        case (cur_insn.op)
            // link address
            op_jal, op_jalr: rec.value = cur_insn.pc + insn_bytes;
            op_lui:          rec.value = cur_insn.imm;
            default:         rec.value = is_load(cur_insn.op) ? load_value : alu_result;
        endcase
    end

    // lsu kick, single cycle in exec
    assign mem_start = (state == st_exec) && is_mem;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            insn_ready <= 1'b0;
            retire_valid <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (insn_valid && insn_ready) begin
                        state <= st_exec;
                        insn_ready <= 1'b0;
                    end else begin
                        // first cycle out of reset lands here
                        insn_ready <= 1'b1;
                    end
                end
                st_exec: begin
                    if (is_mem) begin
                        state <= st_mem_wait;
                    end else begin
                        state <= st_retire;
                        retire_valid <= 1'b1;
                    end
                end
                st_mem_wait: begin
                    if (mem_done) begin
                        state <= st_retire;
                        retire_valid <= 1'b1;
                    end
                end
                st_retire: begin
                    if (retire_ready) begin
                        state <= st_idle;
                        retire_valid <= 1'b0;
                        insn_ready <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (insn_valid && insn_ready) begin
            cur_insn <= insn;
        end
        if ((state == st_exec && !is_mem) || (state == st_mem_wait && mem_done)) begin
            retire <= rec;
        end
    end

    // regfile written on the retire handshake edge
    assign rf_wen = retire_valid && retire_ready && retire.wen;
    assign rf_waddr = retire.rd;
    assign rf_wdata = retire.value;

    // retire record held steady until the consumer takes it
    a_retire_hold: assert property (@(posedge clk) disable iff (rst)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire));

endmodule

// ==== exu_lsu.sv ====
`timescale 1ns/1ns

module exu_lsu (
    input  logic                        clk,
    input  logic                        rst,
    input  exu_pkg::exu_insn_t          cur_insn,
    input  logic [exu_pkg::xlen-1:0]    addr,
    input  logic [exu_pkg::xlen-1:0]    store_src,
    input  logic                        mem_start,
    output logic                        mem_done,
    output logic [exu_pkg::xlen-1:0]    load_value,
    output exu_pkg::mem_ar_t            ar,
    output logic                        ar_valid,
    input  logic                        ar_ready,
    input  exu_pkg::mem_r_t             r,
    input  logic                        r_valid,
    output logic                        r_ready,
    output exu_pkg::mem_aw_t            aw,
    output logic                        aw_valid,
    input  logic                        aw_ready,
    output exu_pkg::mem_w_t             w,
    output logic                        w_valid,
    input  logic                        w_ready,
    input  logic [1:0]                  b_resp,
    input  logic                        b_valid,
    output logic                        b_ready
);
    import exu_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_read_req,
        st_read_wait,
        st_write_req,
        st_write_wait
    } lsu_state_e;

    lsu_state_e        state;
    logic [3:0]        size;
    logic [strb_w-1:0] strb_base;
    logic [strb_w-1:0] strb;
    logic [xlen-1:0]   byte_mask;
    logic [xlen-1:0]   wdata_lane;
    logic [addr_w-1:0] addr_q;
    logic [xlen-1:0]   rdata_q;
    logic [xlen-1:0]   rshift;

    // store lane placement from address bits 2:0
    always_comb begin
        size = op_size(cur_insn.op);
        // 1 -> 01, 2 -> 03, 4 -> 0f, 8 -> ff
        strb_base = strb_w'((9'd1 << size) - 9'd1);
        strb = strb_base << addr[2:0];
        for (int i = 0; i < strb_w; i++) begin
            byte_mask[i*8 +: 8] = {8{strb[i]}};
        end
        wdata_lane = (store_src << {addr[2:0], 3'b000}) & byte_mask;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            aw_valid <= 1'b0;
            w_valid <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (mem_start && is_store(cur_insn.op)) begin
                        state <= st_write_req;
                        aw_valid <= 1'b1;
                        w_valid <= 1'b1;
                    end else if (mem_start) begin
                        state <= st_read_req;
                    end
                end
                st_read_req: begin
                    if (ar_ready) begin
                        state <= st_read_wait;
                    end
                end
                st_read_wait: begin
                    if (r_valid) begin
                        state <= st_idle;
                        mem_done <= 1'b1;
                    end
                end
                st_write_req: begin
                    // aw and w complete independently
                    if (aw_ready) begin
                        aw_valid <= 1'b0;
                    end
                    if (w_ready) begin
                        w_valid <= 1'b0;
                    end
                    if ((!aw_valid || aw_ready) && (!w_valid || w_ready)) begin
                        state <= st_write_wait;
                    end
                end
                st_write_wait: begin
                    if (b_valid) begin
                        state <= st_idle;
                        mem_done <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // request payload, captured once at start
    always_ff @(posedge clk) begin
        if (state == st_idle && mem_start) begin
            addr_q <= addr[addr_w-1:0];
            w <= '{data: wdata_lane, strb: strb};
        end
        if (r_valid && r_ready) begin
            rdata_q <= r.data;
        end
    end

    assign ar.addr = addr_q;
    assign aw.addr = addr_q;
    assign ar_valid = (state == st_read_req);
    assign r_ready = (state == st_read_wait);
    assign b_ready = (state == st_write_wait);

    // load lane select then extend
    always_comb begin
        rshift = rdata_q >> {addr_q[2:0], 3'b000};
        case (cur_insn.op)
            op_lb:   load_value = {{56{rshift[7]}}, rshift[7:0]};
            op_lbu:  load_value = {56'd0, rshift[7:0]};
            op_lh:   load_value = {{48{rshift[15]}}, rshift[15:0]};
            op_lhu:  load_value = {48'd0, rshift[15:0]};
            op_lw:   load_value = {{32{rshift[31]}}, rshift[31:0]};
            op_lwu:  load_value = {32'd0, rshift[31:0]};
            default: load_value = rshift;
        endcase
    end

    // only okay responses are modelled
    a_r_okay: assert property (@(posedge clk) disable iff (rst)
        r_valid && r_ready |-> r.resp == resp_okay);
    a_b_okay: assert property (@(posedge clk) disable iff (rst)
        b_valid && b_ready |-> b_resp == resp_okay);

    // no access may span two 8-byte lines
    a_no_cross: assert property (@(posedge clk) disable iff (rst)
        mem_start |-> ({1'b0, addr[2:0]} + op_size(cur_insn.op)) <= 4'd8);

endmodule

// ==== exu_alu.sv ====
`timescale 1ns/1ns

module exu_alu (
    input  exu_pkg::exu_insn_t         insn,
    input  logic [exu_pkg::xlen-1:0]   src1,
    input  logic [exu_pkg::xlen-1:0]   src2,
    output logic [exu_pkg::xlen-1:0]   result,
    output logic [exu_pkg::xlen-1:0]   next_pc
);
    import exu_pkg::*;

    logic [xlen-1:0] op_b;
    logic [5:0]      shamt;
    logic [xlen-1:0] seq_pc;
    logic [xlen-1:0] br_target;
    logic [xlen-1:0] rs1_imm;
    logic            taken;

    always_comb begin
        // second operand: immediate or rs2
        op_b = insn.use_imm ? insn.imm : src2;
        // rv64 shifts take 6 bits
        shamt = op_b[5:0];
        seq_pc = insn.pc + insn_bytes;
        br_target = insn.pc + insn.imm;
        // effective address for loads/stores, also jalr base
        rs1_imm = src1 + insn.imm;

        case (insn.op)
            op_add:  result = src1 + op_b;
            op_sub:  result = src1 - op_b;
            op_sll:  result = src1 << shamt;
            op_srl:  result = src1 >> shamt;
            op_sra:  result = $signed(src1) >>> shamt;
            op_and:  result = src1 & op_b;
            op_or:   result = src1 | op_b;
            op_xor:  result = src1 ^ op_b;
            op_slt:  result = {63'd0, $signed(src1) < $signed(op_b)};
            op_sltu: result = {63'd0, src1 < op_b};
            op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld,
            op_sb, op_sh, op_sw, op_sd: result = rs1_imm;
            default: result = src1 + op_b;
        endcase

        // branch condition, always on rs1/rs2
        case (insn.op)
            op_beq:  taken = (src1 == src2);
            op_bne:  taken = (src1 != src2);
            op_blt:  taken = ($signed(src1) < $signed(src2));
            op_bgeu: taken = (src1 >= src2);
            default: taken = 1'b0;
        endcase

        if (insn.op == op_jal) begin
            next_pc = br_target;
        end else if (insn.op == op_jalr) begin
            // low bit cleared per isa
            next_pc = {rs1_imm[xlen-1:1], 1'b0};
        end else if (taken) begin
            next_pc = br_target;
        end else begin
            next_pc = seq_pc;
        end
    end

endmodule

// ==== exu_regfile.sv ====
`timescale 1ns/1ns

module exu_regfile (
    input  logic                       clk,
    input  logic                       rst,
    input  exu_pkg::reg_idx_t          raddr1,
    input  exu_pkg::reg_idx_t          raddr2,
    output logic [exu_pkg::xlen-1:0]   rdata1,
    output logic [exu_pkg::xlen-1:0]   rdata2,
    input  logic                       wen,
    input  exu_pkg::reg_idx_t          waddr,
    input  logic [exu_pkg::xlen-1:0]   wdata
);
    import exu_pkg::*;

    // x1..x31 only, x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational read, x0 hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== exu_pkg.sv ====
package exu_pkg;

    // isa widths
    localparam int xlen = 64;
    localparam int addr_w = 32;
    localparam int strb_w = 8;

    // bus response code for a good transfer
    localparam logic [1:0] resp_okay = 2'b00;
    // sequential pc step
    localparam logic [xlen-1:0] insn_bytes = 64'd4;

    typedef logic [4:0] reg_idx_t;

    typedef enum logic [5:0] {
        op_add, op_sub, op_sll, op_srl, op_sra,
        op_and, op_or, op_xor, op_slt, op_sltu,
        op_lui, op_beq, op_bne, op_blt, op_bgeu, op_jal, op_jalr,
        op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld,
        op_sb, op_sh, op_sw, op_sd
    } exu_op_e;

    // decoded instruction as handed over by the decoder
    typedef struct packed {
        exu_op_e         op;
        reg_idx_t        rd;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        logic            use_imm;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
    } exu_insn_t;

    // commit record
    typedef struct packed {
        reg_idx_t        rd;
        logic            wen;
        logic [xlen-1:0] value;
        logic [xlen-1:0] next_pc;
    } exu_retire_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
    } mem_ar_t;

    typedef struct packed {
        logic [xlen-1:0] data;
        logic [1:0]      resp;
    } mem_r_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
    } mem_aw_t;

    typedef struct packed {
        logic [xlen-1:0]   data;
        logic [strb_w-1:0] strb;
    } mem_w_t;

    function automatic logic is_load(exu_op_e op);
        return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
    endfunction

    function automatic logic is_store(exu_op_e op);
        return op inside {op_sb, op_sh, op_sw, op_sd};
    endfunction

    // access size in bytes, 8 for ld/sd and anything else
    function automatic logic [3:0] op_size(exu_op_e op);
        case (op)
            op_lb, op_lbu, op_sb: return 4'd1;
            op_lh, op_lhu, op_sh: return 4'd2;
            op_lw, op_lwu, op_sw: return 4'd4;
            default:              return 4'd8;
        endcase
    endfunction

endpackage
